//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // LUT mode. SET modes advance the byte pointer, SEND modes hold it.
    typedef enum logic [2:0] {
        IDLE,
        SET_I,
        SEND_I,
        SET,
        SEND
    } update_t;

    typedef logic [7:0]  byte_t;   // Panel bus byte.
    typedef logic [3:0]  coord_t;  // Tile index, steps of 20 pixels.
    typedef logic [2:0]  obj_t;    // Object code.
    typedef logic [15:0] color_t;  // RGB565.
    typedef logic [15:0] word_t;   // Counter and address value.

    // Tile request with obj_code in 10:8, Y in 7:4 and X in 3:0.
    typedef logic [10:0] tile_t;

endpackage

`default_nettype wire

//--- apb_tile_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_tile_regs
    import lcd_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        init_done,
    input  logic        busy,
    input  logic [2:0]  count,
    input  logic        full,
    output logic        init_start,
    output logic        push,
    output tile_t       push_data
);

    localparam logic [3:0] addr_ctrl   = 4'h0;
    localparam logic [3:0] addr_tile   = 4'h4;
    localparam logic [3:0] addr_status = 4'h8;

    logic access;
    logic wr_en;
    logic rd_en;
    logic hit_ctrl;
    logic hit_tile;
    logic hit_status;

    assign access     = psel & penable;  // Access phase only.
    assign wr_en      = access & pwrite;
    assign rd_en      = access & ~pwrite;
    assign hit_ctrl   = (paddr == addr_ctrl);
    assign hit_tile   = (paddr == addr_tile);
    assign hit_status = (paddr == addr_status);

    assign pready = 1'b1;

    // Unmapped address, or a tile push that finds the FIFO full.
    assign pslverr = access & ((~hit_ctrl & ~hit_tile & ~hit_status) |
                               (wr_en & hit_tile & full));

    always_comb begin
        prdata = '0;
        if (rd_en && hit_status) begin
            prdata = {25'd0, count, 2'b00, busy, init_done};
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            init_start <= 1'b0;
            push       <= 1'b0;
        end else begin
            // Start is only honoured once, from idle.
            init_start <= wr_en & hit_ctrl & pwdata[0] & ~busy & ~init_done;
            push       <= wr_en & hit_tile & ~full;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && hit_tile) begin
            push_data <= tile_t'(pwdata[10:0]);
        end
    end

endmodule

`default_nettype wire

//--- tile_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tile_fifo
    import lcd_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       push,
    input  tile_t      push_data,
    input  logic       pop,
    output tile_t      head,
    output logic       empty,
    output logic       full,
    output logic [2:0] count
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(fifo_depth - 1);

    tile_t            mem [fifo_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;  // Both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head  = mem[rd_ptr];  // Oldest entry stays until popped.
    assign empty = (count == 3'd0);
    assign full  = (count == 3'(fifo_depth));

endmodule

`default_nettype wire

//--- command_lut.sv
`timescale 1ns/1ps
`default_nettype none

module command_lut
    import lcd_pkg::*;
#(
    parameter int init_delay   = 60000,
    parameter int screen_words = 76900,
    parameter int tile_bytes   = 900
) (
    input  update_t mode,
    input  logic    clk,
    input  logic    nrst,
    input  obj_t    obj_code,
    input  coord_t  X,
    input  coord_t  Y,
    output logic    cmd_finished,
    output byte_t   D,
    output logic    dcx,
    output logic    pause
);

    // One counter serves the delays, the screen fill and the tile data.
    localparam int cnt_max = (init_delay > screen_words) ?
                             ((init_delay > tile_bytes) ? init_delay : tile_bytes) :
                             ((screen_words > tile_bytes) ? screen_words : tile_bytes);
    localparam int cnt_w = $clog2(cnt_max + 1);

    localparam logic [cnt_w-1:0] delay_end = cnt_w'(init_delay);
    localparam logic [cnt_w-1:0] words_end = cnt_w'(screen_words - 1);
    localparam logic [cnt_w-1:0] bytes_end = cnt_w'(tile_bytes);

    // Init table steps with special handling.
    localparam logic [4:0] i_reset   = 5'd1;
    localparam logic [4:0] i_slpout  = 5'd5;
    localparam logic [4:0] i_fill_hi = 5'd18;
    localparam logic [4:0] i_fill_lo = 5'd19;
    localparam logic [4:0] i_done    = 5'd20;

    // Tile table steps with special handling.
    localparam logic [4:0] t_ramwr = 5'd11;
    localparam logic [4:0] t_lo    = 5'd12;
    localparam logic [4:0] t_hi    = 5'd13;
    localparam logic [4:0] t_done  = 5'd14;

    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] next_count;
    logic [4:0]       cmd_num;
    logic [4:0]       next_cmd_num;
    logic [4:0]       sel;
    word_t            sc;
    word_t            ec;
    word_t            sp;
    word_t            ep;
    color_t           color;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            count   <= '0;
            cmd_num <= '0;
        end else begin
            count   <= next_count;
            cmd_num <= next_cmd_num;
        end
    end

    // Y gives the column window and X the page window.
    assign sc = word_t'(Y) * 16'd20;
    assign ec = (word_t'(Y) + 16'd1) * 16'd20;
    assign sp = word_t'(X) * 16'd20;
    assign ep = (word_t'(X) + 16'd1) * 16'd20;

    always_comb begin
        case (obj_code)
            3'd0:    color = 16'hFFFF;
            3'd1:    color = 16'h901E;
            3'd2:    color = 16'h6815;
            3'd3:    color = 16'hF800;
            3'd4:    color = 16'h0814;
            default: color = 16'hFFFF;
        endcase
    end

    // Pointer update.
    always_comb begin
        next_count   = count;
        next_cmd_num = cmd_num;
        sel          = cmd_num;
        pause        = 1'b0;
        case (mode)
            SET_I: begin
                if (cmd_num == i_reset || cmd_num == i_slpout) begin
                    if (count >= delay_end) begin
                        next_count   = '0;
                        next_cmd_num = cmd_num + 5'd1;
                    end else begin
                        next_count = count + cnt_w'(1);
                        pause      = 1'b1;  // Panel needs time here.
                    end
                end else if (cmd_num == i_fill_hi) begin
                    next_cmd_num = i_fill_lo;
                end else if (cmd_num == i_fill_lo) begin
                    if (count >= words_end) begin
                        next_count   = '0;
                        next_cmd_num = i_done;
                    end else begin
                        next_count   = count + cnt_w'(1);
                        next_cmd_num = i_fill_hi;
                    end
                end else if (cmd_num != i_done) begin
                    next_cmd_num = cmd_num + 5'd1;
                end
                sel = next_cmd_num;
            end
            SEND_I: begin
                if (cmd_num == i_done) begin
                    next_cmd_num = '0;
                end
            end
            SET: begin
                if (cmd_num == t_ramwr) begin
                    next_cmd_num = t_hi;          // High byte first.
                    next_count   = cnt_w'(1);
                end else if (cmd_num == t_lo || cmd_num == t_hi) begin
                    if (count >= bytes_end) begin
                        next_count   = '0;
                        next_cmd_num = t_done;
                    end else begin
                        next_count   = count + cnt_w'(1);
                        next_cmd_num = (cmd_num == t_hi) ? t_lo : t_hi;
                    end
                end else if (cmd_num != t_done) begin
                    next_cmd_num = cmd_num + 5'd1;
                end
                sel = next_cmd_num;
            end
            SEND: begin
                if (cmd_num == t_done) begin
                    next_cmd_num = '0;
                end
            end
            default: ;
        endcase
    end

    // Byte and D/C flag for the selected step.
    always_comb begin
        D            = '0;
        dcx          = 1'b0;
        cmd_finished = 1'b0;
        if (mode == SET_I || mode == SEND_I) begin
            case (sel)
                5'd1:  D = 8'h01;               // Software reset.
                5'd2:  D = 8'h28;               // Display off.
                5'd3:  D = 8'h3A;               // Pixel format.
                5'd4: begin
                    D   = 8'h55;                // 16 bits per pixel.
                    dcx = 1'b1;
                end
                5'd5:  D = 8'h11;               // Sleep out.
                5'd6:  D = 8'h29;               // Display on.
                5'd7:  D = 8'h2A;
                5'd8, 5'd9, 5'd10, 5'd13, 5'd14: begin
                    D   = 8'h00;
                    dcx = 1'b1;
                end
                5'd11: begin
                    D   = 8'hF0;
                    dcx = 1'b1;
                end
                5'd12: D = 8'h2B;
                5'd15: begin
                    D   = 8'h01;
                    dcx = 1'b1;
                end
                5'd16: begin
                    D   = 8'h40;
                    dcx = 1'b1;
                end
                5'd17: D = 8'h2C;
                i_fill_hi: begin
                    D   = 8'h08;
                    dcx = 1'b1;
                end
                i_fill_lo: begin
                    D   = 8'h14;
                    dcx = 1'b1;
                end
                i_done: cmd_finished = 1'b1;
                default: ;
            endcase
        end else if (mode == SET || mode == SEND) begin
            dcx = 1'b1;
            case (sel)
                5'd1: begin
                    D   = 8'h2A;                // Column address set.
                    dcx = 1'b0;
                end
                5'd2:  D = sc[15:8];
                5'd3:  D = sc[7:0];
                5'd4:  D = ec[15:8];
                5'd5:  D = ec[7:0];
                5'd6: begin
                    D   = 8'h2B;                // Page address set.
                    dcx = 1'b0;
                end
                5'd7:  D = sp[15:8];
                5'd8:  D = sp[7:0];
                5'd9:  D = ep[15:8];
                5'd10: D = ep[7:0];
                t_ramwr: begin
                    D   = 8'h2C;
                    dcx = 1'b0;
                end
                t_lo:  D = color[7:0];
                t_hi:  D = color[15:8];
                t_done: begin
                    dcx          = 1'b0;
                    cmd_finished = 1'b1;
                end
                default: dcx = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- lcd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer
    import lcd_pkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    input  logic    init_start,
    input  logic    empty,
    input  tile_t   head,
    input  logic    pause,
    input  logic    cmd_finished,
    output update_t mode,
    output obj_t    obj_code,
    output coord_t  X,
    output coord_t  Y,
    output logic    pop,
    output logic    busy,
    output logic    init_done,
    output logic    lcd_wrx,
    output logic    lcd_csx
);

    typedef enum logic [2:0] {
        IDLE,
        INIT_SET,
        INIT_SEND,
        TILE_SET,
        TILE_SEND
    } state_t;

    state_t state;
    state_t next_state;
    tile_t  tile_q;
    logic   start_tile;

    assign start_tile = (state == IDLE) && !empty && init_done;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state     <= IDLE;
            init_done <= 1'b0;
        end else begin
            state <= next_state;
            if (state == INIT_SEND && cmd_finished) begin
                init_done <= 1'b1;
            end
        end
    end

    // Coordinates stay fixed for the whole tile.
    always_ff @(posedge clk) begin
        if (start_tile) begin
            tile_q <= head;
        end
    end

    always_comb begin
        next_state = state;
        mode       = lcd_pkg::IDLE;
        lcd_wrx    = 1'b1;
        pop        = 1'b0;
        case (state)
            IDLE: begin
                if (init_start && !init_done) begin
                    next_state = INIT_SET;
                end else if (start_tile) begin
                    next_state = TILE_SET;
                end
            end
            INIT_SET: begin
                mode       = SET_I;
                lcd_wrx    = pause | cmd_finished;  // Low only for a real byte.
                next_state = pause ? INIT_SET : INIT_SEND;
            end
            INIT_SEND: begin
                mode       = SEND_I;
                next_state = cmd_finished ? IDLE : INIT_SET;
            end
            TILE_SET: begin
                mode       = SET;
                lcd_wrx    = pause | cmd_finished;
                next_state = pause ? TILE_SET : TILE_SEND;
            end
            TILE_SEND: begin
                mode = SEND;
                if (cmd_finished) begin
                    pop        = 1'b1;
                    next_state = IDLE;
                end else begin
                    next_state = TILE_SET;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assign busy     = (state != IDLE);
    assign lcd_csx  = (state == IDLE) || cmd_finished;
    assign X        = tile_q[3:0];
    assign Y        = tile_q[7:4];
    assign obj_code = tile_q[10:8];

endmodule

`default_nettype wire

//--- lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_top
    import lcd_pkg::*;
#(
    parameter int init_delay   = 60000,
    parameter int screen_words = 76900,
    parameter int tile_bytes   = 900,
    parameter int fifo_depth   = 4
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output byte_t       lcd_d,
    output logic        lcd_dcx,
    output logic        lcd_wrx,
    output logic        lcd_csx
);

    logic       init_start;
    logic       init_done;
    logic       busy;
    logic       push;
    tile_t      push_data;
    logic       pop;
    tile_t      head;
    logic       empty;
    logic       full;
    logic [2:0] count;
    update_t    mode;
    obj_t       obj_code;
    coord_t     tile_x;
    coord_t     tile_y;
    logic       pause;
    logic       cmd_finished;

    apb_tile_regs u_regs (
        .clk        (clk),
        .nrst       (nrst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .init_done  (init_done),
        .busy       (busy),
        .count      (count),
        .full       (full),
        .init_start (init_start),
        .push       (push),
        .push_data  (push_data)
    );

    tile_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk        (clk),
        .nrst       (nrst),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (full),
        .count      (count)
    );

    lcd_sequencer u_seq (
        .clk          (clk),
        .nrst         (nrst),
        .init_start   (init_start),
        .empty        (empty),
        .head         (head),
        .pause        (pause),
        .cmd_finished (cmd_finished),
        .mode         (mode),
        .obj_code     (obj_code),
        .X            (tile_x),
        .Y            (tile_y),
        .pop          (pop),
        .busy         (busy),
        .init_done    (init_done),
        .lcd_wrx      (lcd_wrx),
        .lcd_csx      (lcd_csx)
    );

    command_lut #(
        .init_delay   (init_delay),
        .screen_words (screen_words),
        .tile_bytes   (tile_bytes)
    ) u_lut (
        .mode         (mode),
        .clk          (clk),
        .nrst         (nrst),
        .obj_code     (obj_code),
        .X            (tile_x),
        .Y            (tile_y),
        .cmd_finished (cmd_finished),
        .D            (lcd_d),
        .dcx          (lcd_dcx),
        .pause        (pause)
    );

endmodule

`default_nettype wire

//--- tb_lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_top;

    localparam int init_delay   = 20;
    localparam int screen_words = 40;
    localparam int tile_bytes   = 900;
    localparam int fifo_depth   = 4;
    localparam int random_tiles = 30;

    // Expected panel bytes per transaction set the watchdog length.
    localparam int init_len        = 17 + 2 * screen_words;
    localparam int tile_len        = 11 + tile_bytes;
    localparam int total_len       = init_len + (1 + random_tiles + fifo_depth) * tile_len;
    localparam int watchdog_cycles = total_len * 4 + 20000;

    localparam logic [3:0] addr_ctrl   = 4'h0;
    localparam logic [3:0] addr_tile   = 4'h4;
    localparam logic [3:0] addr_status = 4'h8;

    logic        clk;
    logic        nrst;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  lcd_d;
    logic        lcd_dcx;
    logic        lcd_wrx;
    logic        lcd_csx;

    logic [8:0] exp_q[$];  // {dcx, byte} from the model.
    logic [8:0] cap_q[$];  // {dcx, byte} seen on the panel bus.
    logic [8:0] set_byte;  // Byte of the last written SET cycle.
    logic       set_seen;
    int         err_count;
    int         tests_run;
    int         tests_failed;
    int         test_err_start;

    lcd_top #(
        .init_delay   (init_delay),
        .screen_words (screen_words),
        .tile_bytes   (tile_bytes),
        .fifo_depth   (fifo_depth)
    ) dut (
        .clk     (clk),
        .nrst    (nrst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .lcd_d   (lcd_d),
        .lcd_dcx (lcd_dcx),
        .lcd_wrx (lcd_wrx),
        .lcd_csx (lcd_csx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // Bytes are latched where lcd_wrx rises at the end of a SET cycle.
    always @(posedge clk) begin
        if (set_seen === 1'b1 && {lcd_dcx, lcd_d} !== set_byte) begin
            $display("Error: {lcd_dcx,lcd_d} in SEND cycle expected 0x%03h, got 0x%03h",
                     set_byte, {lcd_dcx, lcd_d});
            err_count++;
        end
        set_seen = (nrst === 1'b1 && lcd_wrx === 1'b0);
        set_byte = {lcd_dcx, lcd_d};
        if (set_seen) begin
            cap_q.push_back(set_byte);
            if (lcd_csx !== 1'b0) begin
                $display("Panel write strobe seen while lcd_csx was high");
                err_count++;
            end
        end
    end

    function automatic logic [8:0] init_byte(input int idx);
        case (idx)
            0:       init_byte = 9'h001;  // Software reset.
            1:       init_byte = 9'h028;
            2:       init_byte = 9'h03A;
            3:       init_byte = 9'h155;  // 16 bits per pixel.
            4:       init_byte = 9'h011;
            5:       init_byte = 9'h029;
            6:       init_byte = 9'h02A;
            7:       init_byte = 9'h100;
            8:       init_byte = 9'h100;
            9:       init_byte = 9'h100;
            10:      init_byte = 9'h1F0;  // Last column 240.
            11:      init_byte = 9'h02B;
            12:      init_byte = 9'h100;
            13:      init_byte = 9'h100;
            14:      init_byte = 9'h101;
            15:      init_byte = 9'h140;  // Last page 320.
            default: init_byte = 9'h02C;
        endcase
    endfunction

    function automatic logic [15:0] obj_color(input logic [2:0] obj);
        case (obj)
            3'd1:    obj_color = 16'h901E;
            3'd2:    obj_color = 16'h6815;
            3'd3:    obj_color = 16'hF800;
            3'd4:    obj_color = 16'h0814;
            default: obj_color = 16'hFFFF;
        endcase
    endfunction

    task automatic add_data_word(input logic [15:0] w);
        exp_q.push_back({1'b1, w[15:8]});  // Big-endian.
        exp_q.push_back({1'b1, w[7:0]});
    endtask

    task automatic add_init_expected();
        for (int i = 0; i < 17; i++) begin
            exp_q.push_back(init_byte(i));
        end
        for (int i = 0; i < screen_words; i++) begin
            exp_q.push_back(9'h108);
            exp_q.push_back(9'h114);
        end
    endtask

    task automatic add_tile_expected(input logic [3:0] x, input logic [3:0] y,
                                     input logic [2:0] obj);
        logic [15:0] color;
        color = obj_color(obj);
        exp_q.push_back(9'h02A);
        add_data_word({12'd0, y} * 16'd20);
        add_data_word(({12'd0, y} + 16'd1) * 16'd20);
        exp_q.push_back(9'h02B);
        add_data_word({12'd0, x} * 16'd20);
        add_data_word(({12'd0, x} + 16'd1) * 16'd20);
        exp_q.push_back(9'h02C);
        for (int i = 0; i < tile_bytes; i++) begin
            exp_q.push_back({1'b1, (i % 2 == 0) ? color[15:8] : color[7:0]});
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        err = pslverr;
        check_value("pready", 32'd1, {31'd0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        check_value("pready", 32'd1, {31'd0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_status(output logic [31:0] s);
        logic err;
        apb_read(addr_status, s, err);
        if (err !== 1'b0) begin
            $display("Error: pslverr on STATUS read expected 0x0, got 0x%0h", err);
            err_count++;
        end
    endtask

    task automatic push_tile(input logic [3:0] x, input logic [3:0] y,
                             input logic [2:0] obj, output logic err);
        apb_write(addr_tile, {21'd0, obj, y, x}, err);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
            err_count++;
        end
    endtask

    // Waits for all modelled bytes, then for the sequencer and FIFO to go idle.
    task automatic wait_for_stream();
        logic [31:0] s;
        while (cap_q.size() < exp_q.size()) @(posedge clk);
        read_status(s);
        while (s[1] == 1'b1 || s[6:4] != 3'd0) begin
            read_status(s);
        end
    endtask

    task automatic compare_stream();
        int n;
        int shown;
        shown = 0;
        n = (cap_q.size() < exp_q.size()) ? cap_q.size() : exp_q.size();
        if (cap_q.size() != exp_q.size()) begin
            $display("Error: panel byte count expected 0x%0h, got 0x%0h",
                     exp_q.size(), cap_q.size());
            err_count++;
        end
        for (int i = 0; i < n; i++) begin
            if (cap_q[i] !== exp_q[i]) begin
                if (shown < 8) begin
                    $display("Error: {lcd_dcx,lcd_d} byte %0d expected 0x%03h, got 0x%03h",
                             i, exp_q[i], cap_q[i]);
                end
                shown++;
                err_count++;
            end
        end
        exp_q.delete();
        cap_q.delete();
    endtask

    task automatic start_test();
        test_err_start = err_count;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (err_count == test_err_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end
    endtask

    initial begin
        logic [31:0] s;
        logic        err;
        logic        exp_err;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [2:0]  obj;
        int          gap;
        int          model_count;

        nrst           = 1'b0;
        paddr          = 4'h0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = 32'd0;
        err_count      = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        void'($urandom(57126));
        repeat (2) @(negedge clk);
        nrst = 1'b1;

        start_test();
        check_value("lcd_wrx", 32'd1, {31'd0, lcd_wrx});
        check_value("lcd_csx", 32'd1, {31'd0, lcd_csx});
        read_status(s);
        check_value("prdata", 32'd0, s);
        report_test("reset state");

        start_test();
        add_init_expected();
        apb_write(addr_ctrl, 32'd1, err);
        check_value("pslverr", 32'd0, {31'd0, err});
        wait_for_stream();
        compare_stream();
        read_status(s);
        check_value("prdata", 32'd1, s);  // Only init_done set.
        report_test("initialisation");

        start_test();
        add_tile_expected(4'd2, 4'd7, 3'd3);
        push_tile(4'd2, 4'd7, 3'd3, err);
        check_value("pslverr", 32'd0, {31'd0, err});
        wait_for_stream();
        compare_stream();
        report_test("single tile");

        start_test();
        for (int i = 0; i < random_tiles; i++) begin
            x   = 4'($urandom % 12);
            y   = 4'($urandom % 12);
            obj = 3'($urandom % 8);
            gap = int'($urandom % 200);
            repeat (gap) @(negedge clk);
            read_status(s);
            while (s[6:4] == 3'(fifo_depth)) begin
                read_status(s);
            end
            push_tile(x, y, obj, err);
            if (err !== 1'b0) begin
                $display("Random tile %0d was refused although the FIFO had room", i);
                err_count++;
            end else begin
                add_tile_expected(x, y, obj);
            end
        end
        wait_for_stream();
        compare_stream();
        report_test("random tiles");

        start_test();
        model_count = 0;
        for (int i = 0; i < fifo_depth + 2; i++) begin
            x       = 4'($urandom % 12);
            y       = 4'($urandom % 12);
            obj     = 3'($urandom % 8);
            exp_err = (model_count == fifo_depth);
            push_tile(x, y, obj, err);
            check_value("pslverr", {31'd0, exp_err}, {31'd0, err});
            if (!exp_err) begin
                add_tile_expected(x, y, obj);
                model_count++;  // Nothing is popped this early.
            end
        end
        read_status(s);
        check_value("STATUS fifo count", 32'(model_count), {29'd0, s[6:4]});
        check_value("STATUS busy", 32'd1, {31'd0, s[1]});
        wait_for_stream();
        compare_stream();
        report_test("FIFO back-pressure");

        start_test();
        apb_write(4'hC, 32'd0, err);
        if (err !== 1'b1) begin
            $display("Write to unmapped address 0xC gave no pslverr");
            err_count++;
        end
        apb_read(4'h6, s, err);
        if (err !== 1'b1) begin
            $display("Read from unmapped address 0x6 gave no pslverr");
            err_count++;
        end
        apb_write(addr_ctrl, 32'd1, err);
        check_value("pslverr", 32'd0, {31'd0, err});
        repeat (200) @(negedge clk);
        if (cap_q.size() != 0) begin
            $display("A second start after init_done wrote %0d bytes to the panel",
                     cap_q.size());
            err_count++;
        end
        read_status(s);
        check_value("prdata", 32'd1, s);
        report_test("error paths");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
lcd_pkg.sv
apb_tile_regs.sv
tile_fifo.sv
command_lut.sv
lcd_sequencer.sv
lcd_top.sv
tb_lcd_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_lcd_top
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
